// File: logic/hazard_defines.svh
/* sizes, latencies and CSR byte offsets shared by the hazard unit
   LAT_W must hold MAX_MUL_LAT and REG_ADDR_W must index NUM_REGS */
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

// architectural register count and the width of a register number
`define NUM_REGS    32
`define REG_ADDR_W  5

// the MUL pipe depth bounds the programmable latency
`define MAX_MUL_LAT 15
`define LAT_W       4

// ALU pipe latency in cycles, fixed at build time
`define ALU_LATENCY 2

// byte offsets of the CSRs on the AXI4-Lite slave
`define CSR_CTRL      32'h0
`define CSR_MUL_LAT   32'h4
`define CSR_STATUS    32'h8
`define CSR_ISSUE_CNT 32'hC

`endif

// File: logic/hazard_pkg.sv
/* shared types of the hazard unit
   widths are taken from hazard_defines.svh */
`default_nettype none
`include "hazard_defines.svh"

package hazard_pkg;

  // an architectural register number
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // a pipe latency in cycles, legal values are 1 to MAX_MUL_LAT
  typedef logic [`LAT_W-1:0] latency_t;

  // one AXI4-Lite data word
  typedef logic [31:0] csr_data_t;

  // execution unit select
  // it travels as a single bit on the top level port
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } exec_unit_e;

endpackage

`default_nettype wire

// File: logic/reg_scoreboard.sv
/* pending-write scoreboard, one flag per register, set wins over clear
   two clear ports must never retire the same register in one cycle */
`timescale 1ns/100ps
`default_nettype none
`include "hazard_defines.svh"

module reg_scoreboard #(
  parameter int NUM_CLEAR_PORTS = 1,
  parameter int NUM_TEST_PORTS  = 1,
  parameter bit WRITE_THROUGH   = 1'b0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  set,
  input  hazard_pkg::reg_addr_t set_addr,
  input  logic                  clear      [0:NUM_CLEAR_PORTS-1],
  input  hazard_pkg::reg_addr_t clear_addr [0:NUM_CLEAR_PORTS-1],
  input  hazard_pkg::reg_addr_t test_addr  [0:NUM_TEST_PORTS-1],
  output logic                  found      [0:NUM_TEST_PORTS-1],
  output logic                  empty
);

  // one pending-write flag per architectural register
  logic [`NUM_REGS-1:0] pending;
  // decoded set strobe, at most one bit high
  logic [`NUM_REGS-1:0] set_vec;
  // clear strobes of all ports merged into one vector
  logic [`NUM_REGS-1:0] clear_vec;

  always_comb begin
    set_vec = '0;
    if (set) begin
      set_vec[set_addr] = 1'b1;
    end
  end

  always_comb begin
    clear_vec = '0;
    for (int p = 0; p < NUM_CLEAR_PORTS; p++) begin
      if (clear[p]) begin
        clear_vec[clear_addr[p]] = 1'b1;
      end
    end
  end

  // set is ORed in after the clear mask, so a new writer keeps the flag
  // even when the previous writer of that register retires in the same cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clear_vec) | set_vec;
    end
  end

  assign empty = ~|pending;

  generate
    for (genvar t = 0; t < NUM_TEST_PORTS; t++) begin : gen_test
      if (WRITE_THROUGH) begin : gen_wt
        // a register retiring this cycle already reads as free
        assign found[t] = pending[test_addr[t]] & ~clear_vec[test_addr[t]];
      end else begin : gen_wb
        assign found[t] = pending[test_addr[t]];
      end
    end

    // only one pipe can own a register, so clears never collide
    for (genvar a = 0; a < NUM_CLEAR_PORTS; a++) begin : gen_clr_chk
      for (genvar b = a + 1; b < NUM_CLEAR_PORTS; b++) begin : gen_pair
        a_clear_unique : assert property (@(posedge clk) disable iff (reset)
          !(clear[a] && clear[b] && (clear_addr[a] == clear_addr[b])));
      end
    end
  endgenerate

endmodule

`default_nettype wire

// File: logic/issue_ctrl.sv
/* issues one instruction per cycle when no RAW or WAW hazard is pending
   the source must hold all fields stable while in_valid waits for ready */
`timescale 1ns/100ps
`default_nettype none

module issue_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   issue_enable,
  input  logic                   in_valid,
  input  hazard_pkg::exec_unit_e in_unit,
  input  hazard_pkg::reg_addr_t  in_dest,
  input  hazard_pkg::reg_addr_t  in_src_a,
  input  hazard_pkg::reg_addr_t  in_src_b,
  output logic                   in_ready,
  output logic                   sb_set,
  output hazard_pkg::reg_addr_t  sb_set_addr,
  output hazard_pkg::reg_addr_t  sb_test_addr [0:2],
  input  logic                   sb_found     [0:2],
  output logic                   alu_start,
  output logic                   mul_start,
  output hazard_pkg::reg_addr_t  start_dest,
  output logic                   accepted
);

  // any of the three lookups hit a pending write
  logic hazard;

  // port 0 and 1 catch RAW on the sources, port 2 catches WAW on the dest
  assign sb_test_addr[0] = in_src_a;
  assign sb_test_addr[1] = in_src_b;
  assign sb_test_addr[2] = in_dest;

  assign hazard = sb_found[0] | sb_found[1] | sb_found[2];

  // ready does not wait for valid, so it is visible to the source early
  assign in_ready = issue_enable & ~hazard;
  assign accepted = in_valid & in_ready;

  // the destination turns pending from the next cycle on
  assign sb_set      = accepted;
  assign sb_set_addr = in_dest;

  // start pulses go to exactly one pipe, both share the destination
  assign alu_start  = accepted & (in_unit == hazard_pkg::UNIT_ALU);
  assign mul_start  = accepted & (in_unit == hazard_pkg::UNIT_MUL);
  assign start_dest = in_dest;

  // a stalled instruction stays put until the scoreboard lets it go
  a_hold_stable : assert property (@(posedge clk) disable iff (reset)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_unit) && $stable(in_dest)
                                 && $stable(in_src_a) && $stable(in_src_b)));

  // an instruction occupies a single pipe
  a_one_start : assert property (@(posedge clk) disable iff (reset)
    !(alu_start && mul_start));

endmodule

`default_nettype wire

// File: logic/exec_pipe.sv
/* delay pipe of MAX_MUL_LAT stages, retires a destination latency cycles after start
   the latency may change only while the pipe holds no work */
`timescale 1ns/100ps
`default_nettype none
`include "hazard_defines.svh"

module exec_pipe #(
  parameter bit PROGRAMMABLE  = 1'b1,
  parameter int FIXED_LATENCY = `ALU_LATENCY
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  hazard_pkg::reg_addr_t start_dest,
  input  hazard_pkg::latency_t  latency,
  output logic                  retire_valid,
  output hazard_pkg::reg_addr_t retire_dest
);

  localparam int DEPTH = `MAX_MUL_LAT;

  // latency in use, either the port or the build time constant
  hazard_pkg::latency_t lat_eff;
  // stage 0 is the output, work moves one stage down each cycle
  logic [DEPTH-1:0] stage_valid;
  hazard_pkg::reg_addr_t [DEPTH-1:0] stage_dest;
  // one-hot stage that takes the new start
  logic [DEPTH-1:0] insert;
  // what each stage would get from the stage above it
  logic [DEPTH-1:0] valid_up;
  hazard_pkg::reg_addr_t [DEPTH-1:0] dest_up;
  logic collide;

  generate
    if (PROGRAMMABLE) begin : gen_prog
      assign lat_eff = latency;
    end else begin : gen_fixed
      assign lat_eff = hazard_pkg::latency_t'(FIXED_LATENCY);
    end
  endgenerate

  // a start in stage i reaches the output after i+1 edges
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      insert[i] = start && (lat_eff == hazard_pkg::latency_t'(i + 1));
    end
  end

  assign valid_up = {1'b0, stage_valid[DEPTH-1:1]};
  assign dest_up  = {hazard_pkg::reg_addr_t'(0), stage_dest[DEPTH-1:1]};

  // with a steady latency the stage above the insertion point is always empty
  assign collide = |(insert & valid_up);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stage_valid <= '0;
    end else begin
      stage_valid <= valid_up | insert;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      stage_dest[i] <= insert[i] ? start_dest : dest_up[i];
    end
  end

  assign retire_valid = stage_valid[0];
  assign retire_dest  = stage_dest[0];

  // every start lands in a legal and free stage
  a_insert_free : assert property (@(posedge clk) disable iff (reset)
    start |-> (|insert && !collide));

endmodule

`default_nettype wire

// File: logic/hazard_csr.sv
/* AXI4-Lite CSR slave, one outstanding read and one outstanding write
   awvalid and wvalid are taken together, MUL_LAT is written only while empty */
`timescale 1ns/100ps
`default_nettype none
`include "hazard_defines.svh"

module hazard_csr (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [31:0]           awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  hazard_pkg::csr_data_t wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [31:0]           araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output hazard_pkg::csr_data_t rdata,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [1:0]            rresp,
  input  logic                  sb_empty,
  input  logic                  accepted,
  output logic                  issue_enable,
  output hazard_pkg::latency_t  mul_latency
);

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam hazard_pkg::latency_t MUL_LAT_RESET = hazard_pkg::latency_t'(4);

  typedef enum logic {
    W_IDLE,
    W_RESP
  } wr_state_e;

  typedef enum logic {
    R_IDLE,
    R_DATA
  } rd_state_e;

  wr_state_e wr_state;
  rd_state_e rd_state;
  logic wr_fire;
  logic rd_fire;
  logic ctrl_en;
  hazard_pkg::latency_t mul_lat;
  hazard_pkg::latency_t wr_lat;
  hazard_pkg::csr_data_t issue_cnt;
  hazard_pkg::csr_data_t rd_word;

  // address and data are accepted in the same cycle, once both are offered
  assign wr_fire = (wr_state == W_IDLE) & awvalid & wvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign bvalid  = (wr_state == W_RESP);
  assign bresp   = RESP_OKAY;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state <= W_IDLE;
    end else begin
      case (wr_state)
        W_IDLE: if (wr_fire) wr_state <= W_RESP;
        W_RESP: if (bready) wr_state <= W_IDLE;
        default: wr_state <= W_IDLE;
      endcase
    end
  end

  // a zero latency would lose the instruction, it is raised to one
  assign wr_lat = (wdata[`LAT_W-1:0] == '0) ? hazard_pkg::latency_t'(1)
                                            : wdata[`LAT_W-1:0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_en   <= 1'b0;
      mul_lat   <= MUL_LAT_RESET;
      issue_cnt <= '0;
    end else begin
      // a write to the counter wins over an accept in the same cycle
      if (wr_fire && (awaddr == `CSR_ISSUE_CNT) && |wstrb) begin
        issue_cnt <= '0;
      end else if (accepted) begin
        issue_cnt <= issue_cnt + 1'b1;
      end
      // control fields all sit in byte 0
      if (wr_fire && wstrb[0]) begin
        case (awaddr)
          `CSR_CTRL:    ctrl_en <= wdata[0];
          `CSR_MUL_LAT: mul_lat <= wr_lat;
          default: ;
        endcase
      end
    end
  end

  assign issue_enable = ctrl_en;
  assign mul_latency  = mul_lat;

  assign arready = (rd_state == R_IDLE);
  assign rd_fire = arvalid & arready;
  assign rvalid  = (rd_state == R_DATA);
  assign rresp   = RESP_OKAY;

  // unmapped offsets read as zero
  always_comb begin
    case (araddr)
      `CSR_CTRL:      rd_word = {31'b0, ctrl_en};
      `CSR_MUL_LAT:   rd_word = hazard_pkg::csr_data_t'(mul_lat);
      `CSR_STATUS:    rd_word = {31'b0, sb_empty};
      `CSR_ISSUE_CNT: rd_word = issue_cnt;
      default:        rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state <= R_IDLE;
    end else begin
      case (rd_state)
        R_IDLE: if (rd_fire) rd_state <= R_DATA;
        R_DATA: if (rready) rd_state <= R_IDLE;
        default: rd_state <= R_IDLE;
      endcase
    end
  end

  // the read word is captured with the address and held through the stall
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
    end
  end

  // MUL work in flight would retire at the wrong cycle after a change
  a_lat_write_idle : assert property (@(posedge clk) disable iff (reset)
    (wr_fire && (awaddr == `CSR_MUL_LAT)) |-> sb_empty);

endmodule

`default_nettype wire

// File: logic/hazard_top.sv
/* register hazard unit of an in-order issue stage with AXI4-Lite control
   in_unit is 0 for the ALU pipe and 1 for the MUL pipe */
`timescale 1ns/100ps
`default_nettype none
`include "hazard_defines.svh"

module hazard_top (
  input  logic                  clk,
  input  logic                  reset,
  // instruction channel
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic                  in_unit,
  input  hazard_pkg::reg_addr_t in_dest,
  input  hazard_pkg::reg_addr_t in_src_a,
  input  hazard_pkg::reg_addr_t in_src_b,
  // retire channels, no back-pressure
  output logic                  alu_retire_valid,
  output hazard_pkg::reg_addr_t alu_retire_dest,
  output logic                  mul_retire_valid,
  output hazard_pkg::reg_addr_t mul_retire_dest,
  // AXI4-Lite slave
  input  logic [31:0]           awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  hazard_pkg::csr_data_t wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [31:0]           araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output hazard_pkg::csr_data_t rdata,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [1:0]            rresp
);

  logic issue_enable;
  hazard_pkg::latency_t mul_latency;
  logic sb_empty;
  logic accepted;
  logic sb_set;
  hazard_pkg::reg_addr_t sb_set_addr;
  hazard_pkg::reg_addr_t sb_test_addr [0:2];
  logic sb_found [0:2];
  logic sb_clear [0:1];
  hazard_pkg::reg_addr_t sb_clear_addr [0:1];
  logic alu_start;
  logic mul_start;
  hazard_pkg::reg_addr_t start_dest;

  hazard_csr u_csr (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rvalid, .rready, .rresp,
    .sb_empty, .accepted, .issue_enable, .mul_latency
  );

  issue_ctrl u_issue (
    .clk, .reset, .issue_enable,
    .in_valid,
    .in_unit (hazard_pkg::exec_unit_e'(in_unit)),
    .in_dest, .in_src_a, .in_src_b, .in_ready,
    .sb_set, .sb_set_addr, .sb_test_addr, .sb_found,
    .alu_start, .mul_start, .start_dest, .accepted
  );

  // clear port 0 belongs to the ALU pipe and port 1 to the MUL pipe
  assign sb_clear[0]      = alu_retire_valid;
  assign sb_clear_addr[0] = alu_retire_dest;
  assign sb_clear[1]      = mul_retire_valid;
  assign sb_clear_addr[1] = mul_retire_dest;

  reg_scoreboard #(
    .NUM_CLEAR_PORTS (2),
    .NUM_TEST_PORTS  (3),
    .WRITE_THROUGH   (1'b1)
  ) u_scoreboard (
    .clk, .reset,
    .set        (sb_set),
    .set_addr   (sb_set_addr),
    .clear      (sb_clear),
    .clear_addr (sb_clear_addr),
    .test_addr  (sb_test_addr),
    .found      (sb_found),
    .empty      (sb_empty)
  );

  // the ALU pipe takes its latency from the module default
  exec_pipe #(.PROGRAMMABLE(1'b0)) alu_pipe (
    .clk, .reset,
    .start        (alu_start),
    .start_dest   (start_dest),
    .latency      (hazard_pkg::latency_t'(`ALU_LATENCY)),
    .retire_valid (alu_retire_valid),
    .retire_dest  (alu_retire_dest)
  );

  exec_pipe #(.PROGRAMMABLE(1'b1)) mul_pipe (
    .clk, .reset,
    .start        (mul_start),
    .start_dest   (start_dest),
    .latency      (mul_latency),
    .retire_valid (mul_retire_valid),
    .retire_dest  (mul_retire_dest)
  );

endmodule

`default_nettype wire

// File: tb/hazard_tb.sv
/* testbench of the hazard unit, stops at the first mismatch
   CSR writes of CTRL and MUL_LAT are tracked from the AXI write channel */
`timescale 1ns/100ps
`default_nettype none
`include "hazard_defines.svh"

module hazard_tb;

  localparam int RESET_CYCLES = 10;
  // one held for the enable, directed instructions, latency batch and random stream
  localparam int NUM_INSTR    = 1 + 6 + 5 + 200;
  // ten reads and four writes
  localparam int AXI_OPS      = 14;
  localparam int CYCLE_LIMIT  = NUM_INSTR * 20 + AXI_OPS * 8 + RESET_CYCLES
                                + 4 * `MAX_MUL_LAT;

  // an expected retire, with the monitor cycle in which its valid is due
  typedef struct packed {
    int unsigned           due;
    hazard_pkg::reg_addr_t dest;
  } retire_t;

  logic clk = 1'b0;
  logic reset;
  logic in_valid;
  logic in_ready;
  logic in_unit;
  hazard_pkg::reg_addr_t in_dest;
  hazard_pkg::reg_addr_t in_src_a;
  hazard_pkg::reg_addr_t in_src_b;
  logic alu_retire_valid;
  hazard_pkg::reg_addr_t alu_retire_dest;
  logic mul_retire_valid;
  hazard_pkg::reg_addr_t mul_retire_dest;
  logic [31:0] awaddr;
  logic awvalid;
  logic awready;
  hazard_pkg::csr_data_t wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [31:0] araddr;
  logic arvalid;
  logic arready;
  hazard_pkg::csr_data_t rdata;
  logic rvalid;
  logic rready;
  logic [1:0] rresp;

  // reference model state, owned by the monitor
  logic [`NUM_REGS-1:0] pending = '0;
  logic [`NUM_REGS-1:0] retiring;
  logic model_enable = 1'b0;
  hazard_pkg::latency_t mul_lat_model = hazard_pkg::latency_t'(4);
  retire_t alu_q[$];
  retire_t mul_q[$];
  retire_t entry;
  logic exp_alu;
  logic exp_mul;
  int unsigned accept_count = 0;
  int unsigned max_mul_q = 0;
  int unsigned cycle = 0;
  integer seed = 50759;
  hazard_pkg::csr_data_t rd_val;

  // the testbench signals carry the port names of the top level
  hazard_top dut (.*);

  always #10 clk = ~clk;

  task end_with_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      end_with_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input hazard_pkg::reg_addr_t got,
                            input hazard_pkg::reg_addr_t exp);
    if (got !== exp) begin
      end_with_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input hazard_pkg::csr_data_t got,
                            input hazard_pkg::csr_data_t exp);
    if (got !== exp) begin
      end_with_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // ready needs the enable and none of the three registers still pending,
  // where a register retiring in this cycle already counts as free
  function automatic logic expect_ready(input logic en, input logic [`NUM_REGS-1:0] pend,
                                        input logic [`NUM_REGS-1:0] ret,
                                        input hazard_pkg::reg_addr_t d,
                                        input hazard_pkg::reg_addr_t a,
                                        input hazard_pkg::reg_addr_t b);
    logic [`NUM_REGS-1:0] busy;
    busy = pend & ~ret;
    return en && !busy[d] && !busy[a] && !busy[b];
  endfunction

  // count the cycles and end the run once the limit is passed
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > CYCLE_LIMIT) begin
      end_with_failure($sformatf("timeout after %0d cycles, the DUT stopped responding", cycle));
    end
  end

  // all DUT outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      retiring = '0;
      exp_alu = (alu_q.size() > 0) ? (alu_q[0].due == cycle) : 1'b0;
      exp_mul = (mul_q.size() > 0) ? (mul_q[0].due == cycle) : 1'b0;
      check_bit("alu_retire_valid", alu_retire_valid, exp_alu);
      check_bit("mul_retire_valid", mul_retire_valid, exp_mul);
      if (exp_alu) begin
        entry = alu_q.pop_front();
        check_addr("alu_retire_dest", alu_retire_dest, entry.dest);
        retiring[entry.dest] = 1'b1;
      end
      if (exp_mul) begin
        entry = mul_q.pop_front();
        check_addr("mul_retire_dest", mul_retire_dest, entry.dest);
        retiring[entry.dest] = 1'b1;
      end
      if (in_valid) begin
        check_bit("in_ready", in_ready,
                  expect_ready(model_enable, pending, retiring, in_dest, in_src_a, in_src_b));
      end
      // the accepting edge is the next rising edge, set wins over clear
      pending = pending & ~retiring;
      if (in_valid && in_ready) begin
        pending[in_dest] = 1'b1;
        accept_count = accept_count + 1;
        entry.dest = in_dest;
        if (in_unit == hazard_pkg::UNIT_MUL) begin
          entry.due = cycle + int'(mul_lat_model);
          mul_q.push_back(entry);
        end else begin
          entry.due = cycle + `ALU_LATENCY;
          alu_q.push_back(entry);
        end
      end
      if (mul_q.size() > max_mul_q) begin
        max_mul_q = mul_q.size();
      end
      // CSR writes take effect at the next edge, a zero MUL latency becomes one
      if (awvalid && awready && wvalid && wstrb[0]) begin
        if (awaddr == `CSR_CTRL) begin
          model_enable = wdata[0];
        end else if (awaddr == `CSR_MUL_LAT) begin
          mul_lat_model = (wdata[`LAT_W-1:0] == '0) ? hazard_pkg::latency_t'(1)
                                                    : wdata[`LAT_W-1:0];
        end
      end
    end
  end

  // every stimulus task starts and ends just after a rising edge
  task axi_write(input logic [31:0] addr, input hazard_pkg::csr_data_t data);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    check_data("bresp", hazard_pkg::csr_data_t'(bresp), 32'h0);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task axi_read(input logic [31:0] addr, output hazard_pkg::csr_data_t data);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    check_data("rresp", hazard_pkg::csr_data_t'(rresp), 32'h0);
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task read_expect(input string name, input logic [31:0] addr,
                   input hazard_pkg::csr_data_t exp);
    axi_read(addr, rd_val);
    check_data(name, rd_val, exp);
  endtask

  // holds the instruction until it is accepted, a following call in the
  // same time step overrides the drop of in_valid for back-to-back issue
  task send(input hazard_pkg::exec_unit_e unit, input hazard_pkg::reg_addr_t dest,
            input hazard_pkg::reg_addr_t src_a, input hazard_pkg::reg_addr_t src_b);
    in_valid <= 1'b1;
    in_unit  <= unit;
    in_dest  <= dest;
    in_src_a <= src_a;
    in_src_b <= src_b;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // eight registers only, so hazards are frequent
  task send_random();
    integer r;
    r = $random(seed);
    if (r[12:10] == 3'd0) begin
      @(posedge clk);
    end
    send(hazard_pkg::exec_unit_e'(r[0]), hazard_pkg::reg_addr_t'(r[3:1]),
         hazard_pkg::reg_addr_t'(r[6:4]), hazard_pkg::reg_addr_t'(r[9:7]));
  endtask

  task drain();
    while (alu_q.size() != 0 || mul_q.size() != 0 || pending != '0) @(posedge clk);
  endtask

  initial begin
    reset    = 1'b1;
    in_valid = 1'b0;
    in_unit  = 1'b0;
    in_dest  = '0;
    in_src_a = '0;
    in_src_b = '0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("in_ready", in_ready, 1'b0);
    check_bit("alu_retire_valid", alu_retire_valid, 1'b0);
    check_bit("mul_retire_valid", mul_retire_valid, 1'b0);
    check_bit("bvalid", bvalid, 1'b0);
    check_bit("rvalid", rvalid, 1'b0);
    @(posedge clk);
    read_expect("CTRL", `CSR_CTRL, 32'h0);
    read_expect("MUL_LAT", `CSR_MUL_LAT, 32'h4);
    read_expect("STATUS", `CSR_STATUS, 32'h1);
    read_expect("ISSUE_CNT", `CSR_ISSUE_CNT, 32'h0);

    // the instruction waits with ready low until issue is enabled
    fork
      send(hazard_pkg::UNIT_MUL, 5'd10, 5'd11, 5'd12);
      begin
        repeat (5) @(posedge clk);
        axi_write(`CSR_CTRL, 32'h1);
      end
    join
    read_expect("CTRL", `CSR_CTRL, 32'h1);

    // dependent chains, r2 issues in the cycle that r1 retires
    send(hazard_pkg::UNIT_ALU, 5'd1, 5'd0, 5'd0);
    send(hazard_pkg::UNIT_ALU, 5'd2, 5'd1, 5'd1);
    send(hazard_pkg::UNIT_MUL, 5'd3, 5'd2, 5'd0);
    send(hazard_pkg::UNIT_ALU, 5'd4, 5'd0, 5'd3);
    // WAW on r4, then an independent instruction right behind it
    send(hazard_pkg::UNIT_MUL, 5'd4, 5'd5, 5'd6);
    send(hazard_pkg::UNIT_ALU, 5'd7, 5'd8, 5'd9);
    drain();

    // a latency of zero is raised to one, which gives back-to-back MUL chains
    axi_write(`CSR_MUL_LAT, 32'h0);
    read_expect("MUL_LAT", `CSR_MUL_LAT, 32'h1);
    send(hazard_pkg::UNIT_MUL, 5'd1, 5'd0, 5'd0);
    send(hazard_pkg::UNIT_MUL, 5'd2, 5'd1, 5'd0);
    send(hazard_pkg::UNIT_MUL, 5'd3, 5'd2, 5'd2);
    send(hazard_pkg::UNIT_ALU, 5'd4, 5'd3, 5'd3);
    send(hazard_pkg::UNIT_MUL, 5'd5, 5'd4, 5'd4);
    drain();

    axi_write(`CSR_MUL_LAT, 32'hF);
    read_expect("MUL_LAT", `CSR_MUL_LAT, 32'hF);
    repeat (200) send_random();
    drain();
    if (max_mul_q < 2) begin
      end_with_failure("the random stream never had two MUL instructions in flight");
    end

    read_expect("STATUS", `CSR_STATUS, 32'h1);
    read_expect("ISSUE_CNT", `CSR_ISSUE_CNT, hazard_pkg::csr_data_t'(accept_count));
    axi_write(`CSR_ISSUE_CNT, 32'h0);
    read_expect("ISSUE_CNT", `CSR_ISSUE_CNT, 32'h0);

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/hazard_pkg.sv
logic/reg_scoreboard.sv
logic/issue_ctrl.sv
logic/exec_pipe.sv
logic/hazard_csr.sv
logic/hazard_top.sv
tb/hazard_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the hazard unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module hazard_tb -f vlog.f -Mdir "$BUILD_DIR" -o hazard_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  echo "** FAIL **"
  exit 1
fi

"./$BUILD_DIR/hazard_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  echo "** FAIL **"
  exit 1
fi

if grep -q -x -F "** PASS **" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
